//--- usb_sniffer_pkg.sv
/*
 * Shared types, log word layout and USB PID codes for the bus-capture engine.
 * Imported by every design block that builds or moves log words.
 */
`default_nettype none

package usb_sniffer_pkg;

    //----------------------------------------------------------
    // Data widths
    //----------------------------------------------------------
    typedef logic [7:0]  utmi_byte_t;
    typedef logic [7:0]  pid_t;
    typedef logic [10:0] frame_num_t;
    typedef logic [15:0] token_data_t;
    typedef logic [15:0] data_len_t;
    typedef logic [31:0] log_word_t;
    typedef logic [31:0] mem_addr_t;

    // Header type field, code 2 (bus reset) not produced here
    typedef enum logic [3:0]
    {
        LOG_TYPE_SOF    = 4'd1,
        LOG_TYPE_TOKEN  = 4'd3,
        LOG_TYPE_HSHAKE = 4'd4,
        LOG_TYPE_DATA   = 4'd5
    } log_type_t;

    // What the receiver presents in one cycle
    typedef enum logic [2:0]
    {
        EVT_NONE,
        EVT_SOF,
        EVT_TOKEN,
        EVT_HSHAKE,
        EVT_DATA_BYTE,
        EVT_DATA_FLUSH,
        EVT_DATA_END
    } rx_evt_t;

    //----------------------------------------------------------
    // Log word field positions
    //----------------------------------------------------------
    localparam int LOG_PID_LSB   = 0;
    localparam int LOG_PID_W     = 4;
    // Token bytes or data length
    localparam int LOG_FIELD_LSB = 4;
    localparam int LOG_FRAME_LSB = 0;
    localparam int LOG_CYCLE_LSB = 20;
    localparam int LOG_CYCLE_W   = 8;
    localparam int LOG_TYPE_LSB  = 28;

    // Byte step between log words
    localparam mem_addr_t WORD_BYTES = 32'd4;

    //----------------------------------------------------------
    // PID codes
    //----------------------------------------------------------
    localparam pid_t PID_OUT   = 8'hE1;
    localparam pid_t PID_IN    = 8'h69;
    localparam pid_t PID_SOF   = 8'hA5;
    localparam pid_t PID_SETUP = 8'h2D;
    localparam pid_t PID_PING  = 8'hB4;
    localparam pid_t PID_DATA0 = 8'hC3;
    localparam pid_t PID_DATA1 = 8'h4B;
    localparam pid_t PID_DATA2 = 8'h87;
    localparam pid_t PID_MDATA = 8'h0F;
    localparam pid_t PID_ACK   = 8'hD2;
    localparam pid_t PID_NAK   = 8'h5A;
    localparam pid_t PID_STALL = 8'h1E;
    localparam pid_t PID_NYET  = 8'h96;
    localparam pid_t PID_PRE   = 8'h3C;
    localparam pid_t PID_SPLIT = 8'h78;

endpackage

`default_nettype wire

//--- usb_rx_event_if.sv
/*
 * Decoded packet events, one per cycle, from the UTMI receiver to the word builder.
 */
`timescale 1ns/100ps
`default_nettype none

interface usb_rx_event_if;
    import usb_sniffer_pkg::*;

    rx_evt_t     evt;
    pid_t        pid;
    frame_num_t  frame;
    token_data_t token;
    // Payload bytes seen before this cycle
    data_len_t   count;
    utmi_byte_t  data;

    modport rx_mp
    (
        output evt, pid, frame, token, count, data
    );

    modport build_mp
    (
        input evt, pid, frame, token, count, data
    );

endinterface

`default_nettype wire

//--- utmi_packet_rx.sv
/*
 * UTMI receive side packet decoder. Classifies each packet by PID and
 * presents token, SOF, handshake and payload events on the event interface.
 */
`timescale 1ns/100ps
`default_nettype none

module utmi_packet_rx
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  usb_sniffer_pkg::utmi_byte_t   utmi_data_i,
    input  logic                          utmi_rxvalid_i,
    input  logic                          utmi_rxactive_i,
    input  logic                          enable_i,
    usb_rx_event_if.rx_mp                 evt
);
    import usb_sniffer_pkg::*;

    typedef enum logic [3:0]
    {
        RX_IDLE,
        RX_TOKEN2,
        RX_TOKEN3,
        RX_TOKEN_DONE,
        RX_SOF2,
        RX_SOF3,
        RX_SOF_DONE,
        RX_DATA,
        RX_DATA_DONE,
        RX_HSHAKE_DONE,
        RX_IGNORE
    } rx_state_t;

    rx_state_t   state_q;
    rx_state_t   next_state_r;
    logic        active_q;
    pid_t        pid_q;
    frame_num_t  frame_q;
    token_data_t token_q;
    data_len_t   count_q;

    //----------------------------------------------------------
    // Packet framing
    //----------------------------------------------------------
    wire sample_w    = utmi_rxvalid_i && utmi_rxactive_i;
    // First valid byte while idle is the PID
    wire start_pkt_w = !active_q && sample_w && enable_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            active_q <= 1'b0;
        else if (!active_q)
            active_q <= start_pkt_w;
        else if (!utmi_rxactive_i)
            active_q <= 1'b0;
    end

    //----------------------------------------------------------
    // PID state machine
    //----------------------------------------------------------
    always_comb
    begin
        next_state_r = state_q;
        case (state_q)
        // Done states fall back to idle but still accept a back-to-back PID
        RX_IDLE, RX_TOKEN_DONE, RX_SOF_DONE, RX_DATA_DONE, RX_HSHAKE_DONE:
        begin
            next_state_r = RX_IDLE;
            if (start_pkt_w)
            begin
                case (utmi_data_i)
                PID_OUT, PID_IN, PID_SETUP, PID_PING:
                    next_state_r = RX_TOKEN2;
                PID_SOF:
                    next_state_r = RX_SOF2;
                PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA:
                    next_state_r = RX_DATA;
                PID_ACK, PID_NAK, PID_STALL, PID_NYET:
                    next_state_r = RX_HSHAKE_DONE;
                // PRE, SPLIT and unknown codes, not logged
                default:
                    next_state_r = RX_IGNORE;
                endcase
            end
        end
        RX_TOKEN2, RX_TOKEN3, RX_SOF2, RX_SOF3:
        begin
            if (sample_w)
                next_state_r = rx_state_t'(state_q + 4'd1);
            else if (!utmi_rxactive_i)
                next_state_r = RX_IDLE;
        end
        RX_DATA:
        begin
            if (!utmi_rxactive_i)
                next_state_r = RX_DATA_DONE;
        end
        RX_IGNORE:
        begin
            if (!utmi_rxactive_i)
                next_state_r = RX_IDLE;
        end
        default:
            next_state_r = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= RX_IDLE;
        else
            state_q <= next_state_r;
    end

    //----------------------------------------------------------
    // Field capture
    //----------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (start_pkt_w)
            pid_q <= utmi_data_i;
        // Frame number is 11 bits, upper CRC bits dropped
        if (state_q == RX_SOF2 && sample_w)
            frame_q[7:0] <= utmi_data_i;
        if (state_q == RX_SOF3 && sample_w)
            frame_q[10:8] <= utmi_data_i[2:0];
        if (state_q == RX_TOKEN2 && sample_w)
            token_q[7:0] <= utmi_data_i;
        if (state_q == RX_TOKEN3 && sample_w)
            token_q[15:8] <= utmi_data_i;
    end

    // Payload byte count
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            count_q <= '0;
        else if (start_pkt_w)
            count_q <= '0;
        else if (state_q == RX_DATA && sample_w)
            count_q <= count_q + data_len_t'(1);
    end

    //----------------------------------------------------------
    // Event output
    //----------------------------------------------------------
    always_comb
    begin
        evt.evt = EVT_NONE;
        case (state_q)
        RX_SOF_DONE:
            evt.evt = EVT_SOF;
        RX_TOKEN_DONE:
            evt.evt = EVT_TOKEN;
        RX_HSHAKE_DONE:
            evt.evt = EVT_HSHAKE;
        RX_DATA_DONE:
            evt.evt = EVT_DATA_END;
        RX_DATA:
        begin
            if (sample_w)
                evt.evt = EVT_DATA_BYTE;
            else if (!utmi_rxactive_i)
                evt.evt = EVT_DATA_FLUSH;
        end
        default:
            evt.evt = EVT_NONE;
        endcase
    end

    assign evt.pid   = pid_q;
    assign evt.frame = frame_q;
    assign evt.token = token_q;
    assign evt.count = count_q;
    assign evt.data  = utmi_data_i;

endmodule

`default_nettype wire

//--- log_word_builder.sv
/*
 * Turns receiver events into 32-bit log words: packed payload words and
 * per-packet headers. Output word and strobe hold while memory stalls.
 */
`timescale 1ns/100ps
`default_nettype none

module log_word_builder
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    usb_rx_event_if.build_mp             ev,
    input  logic                         ignore_sof_i,
    input  logic                         mem_stall_i,
    output logic                         wr_o,
    output usb_sniffer_pkg::log_word_t   word_o
);
    import usb_sniffer_pkg::*;

    log_word_t   pack_q;
    log_word_t   pack_r;
    log_word_t   word_r;
    logic        wr_r;
    logic        hdr_r;
    log_word_t   word_q;
    logic        wr_q;
    logic [15:0] cycle_q;

    //----------------------------------------------------------
    // Payload packing, little-endian
    //----------------------------------------------------------
    always_comb
    begin
        case (ev.count[1:0])
        2'd0:
            pack_r = {24'b0, ev.data};
        2'd1:
            pack_r = {16'b0, ev.data, pack_q[7:0]};
        2'd2:
            pack_r = {8'b0, ev.data, pack_q[15:0]};
        default:
            pack_r = {ev.data, pack_q[23:0]};
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (ev.evt == EVT_DATA_BYTE)
            pack_q <= pack_r;
    end

    //----------------------------------------------------------
    // Next log word
    //----------------------------------------------------------
    always_comb
    begin
        word_r = '0;
        wr_r   = 1'b0;
        hdr_r  = 1'b0;
        // Headers all carry the coarse cycle delta
        word_r[LOG_CYCLE_LSB +: LOG_CYCLE_W] = cycle_q[15:8];
        case (ev.evt)
        EVT_SOF:
        begin
            word_r[LOG_FRAME_LSB +: $bits(frame_num_t)] = ev.frame;
            word_r[LOG_TYPE_LSB +: $bits(log_type_t)]   = LOG_TYPE_SOF;
            hdr_r = !ignore_sof_i;
        end
        EVT_TOKEN:
        begin
            word_r[LOG_PID_LSB +: LOG_PID_W]              = ev.pid[3:0];
            word_r[LOG_FIELD_LSB +: $bits(token_data_t)]  = ev.token;
            word_r[LOG_TYPE_LSB +: $bits(log_type_t)]     = LOG_TYPE_TOKEN;
            hdr_r = 1'b1;
        end
        EVT_HSHAKE:
        begin
            word_r[LOG_PID_LSB +: LOG_PID_W]          = ev.pid[3:0];
            word_r[LOG_TYPE_LSB +: $bits(log_type_t)] = LOG_TYPE_HSHAKE;
            hdr_r = 1'b1;
        end
        EVT_DATA_END:
        begin
            word_r[LOG_PID_LSB +: LOG_PID_W]            = ev.pid[3:0];
            word_r[LOG_FIELD_LSB +: $bits(data_len_t)]  = ev.count;
            word_r[LOG_TYPE_LSB +: $bits(log_type_t)]   = LOG_TYPE_DATA;
            hdr_r = 1'b1;
        end
        // Full word on every fourth byte
        EVT_DATA_BYTE:
        begin
            word_r = pack_r;
            wr_r   = (ev.count[1:0] == 2'd3);
        end
        // Partial tail only, upper bytes already zero
        EVT_DATA_FLUSH:
        begin
            word_r = pack_q;
            wr_r   = (ev.count[1:0] != 2'd0);
        end
        default:
            wr_r = 1'b0;
        endcase
        wr_r = wr_r || hdr_r;
    end

    //----------------------------------------------------------
    // Output register, frozen under stall
    //----------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            wr_q <= 1'b0;
        else if (!wr_q || !mem_stall_i)
            wr_q <= wr_r;
    end

    always_ff @(posedge clk_i)
    begin
        if (!wr_q || !mem_stall_i)
            word_q <= word_r;
    end

    // Ticks since last header, saturating
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            cycle_q <= '0;
        else if (hdr_r)
            cycle_q <= '0;
        else if (cycle_q != 16'hFFFF)
            cycle_q <= cycle_q + 16'd1;
    end

    assign wr_o   = wr_q;
    assign word_o = word_q;

endmodule

`default_nettype wire

//--- log_mem_writer.sv
/*
 * Write-only Wishbone master into a circular log buffer.
 * Steps the address on each accepted write and keeps the sticky status flags.
 */
`timescale 1ns/100ps
`default_nettype none

module log_mem_writer
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         enable_i,
    input  usb_sniffer_pkg::mem_addr_t   buffer_base_i,
    input  usb_sniffer_pkg::mem_addr_t   buffer_end_i,
    input  logic                         wr_i,
    input  usb_sniffer_pkg::log_word_t   word_i,
    input  logic                         mem_stall_i,
    output usb_sniffer_pkg::mem_addr_t   mem_addr_o,
    output usb_sniffer_pkg::log_word_t   mem_data_o,
    output logic [3:0]                   mem_sel_o,
    output logic                         mem_stb_o,
    output logic                         mem_we_o,
    output logic                         sts_wrapped_o,
    output logic                         sts_triggered_o
);
    import usb_sniffer_pkg::*;

    logic      enable_q;
    mem_addr_t addr_q;
    logic      wrapped_q;
    logic      triggered_q;

    // Capture restart on enable rising edge
    wire enable_rise_w = enable_i && !enable_q;
    wire accept_w      = wr_i && !mem_stall_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            enable_q    <= 1'b0;
            addr_q      <= '0;
            wrapped_q   <= 1'b0;
            triggered_q <= 1'b0;
        end
        else
        begin
            enable_q <= enable_i;
            if (enable_rise_w)
            begin
                addr_q      <= buffer_base_i;
                wrapped_q   <= 1'b0;
                triggered_q <= 1'b0;
            end
            else if (accept_w)
            begin
                triggered_q <= 1'b1;
                // Last slot taken, go back to base
                if (addr_q == buffer_end_i)
                begin
                    addr_q    <= buffer_base_i;
                    wrapped_q <= 1'b1;
                end
                else
                    addr_q <= addr_q + WORD_BYTES;
            end
        end
    end

    //----------------------------------------------------------
    // Wishbone outputs
    //----------------------------------------------------------
    assign mem_addr_o      = addr_q;
    assign mem_data_o      = word_i;
    assign mem_sel_o       = 4'b1111;
    assign mem_stb_o       = wr_i;
    assign mem_we_o        = 1'b1;
    assign sts_wrapped_o   = wrapped_q;
    assign sts_triggered_o = triggered_q;

endmodule

`default_nettype wire

//--- usb_sniffer_top.sv
/*
 * USB bus-capture engine top level. UTMI receive side in, log words out
 * over a write-only Wishbone master; configuration on plain ports.
 */
`timescale 1ns/100ps
`default_nettype none

module usb_sniffer_top
(
    input  logic                         clk_i,
    input  logic                         rst_i,

    // UTMI receive side
    input  usb_sniffer_pkg::utmi_byte_t  utmi_data_i,
    input  logic                         utmi_rxvalid_i,
    input  logic                         utmi_rxactive_i,

    // Configuration
    input  logic                         enable_i,
    input  logic                         ignore_sof_i,
    input  usb_sniffer_pkg::mem_addr_t   buffer_base_i,
    input  usb_sniffer_pkg::mem_addr_t   buffer_end_i,

    // Wishbone master, write only
    output usb_sniffer_pkg::mem_addr_t   mem_addr_o,
    output usb_sniffer_pkg::log_word_t   mem_data_o,
    output logic [3:0]                   mem_sel_o,
    output logic                         mem_stb_o,
    output logic                         mem_we_o,
    input  logic                         mem_stall_i,

    // Status
    output logic                         sts_wrapped_o,
    output logic                         sts_triggered_o
);
    import usb_sniffer_pkg::*;

    logic      wr_w;
    log_word_t word_w;

    usb_rx_event_if u_evt_if ();

    //----------------------------------------------------------
    // Receiver, word builder, memory writer
    //----------------------------------------------------------
    utmi_packet_rx u_rx
    (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .utmi_data_i     (utmi_data_i),
        .utmi_rxvalid_i  (utmi_rxvalid_i),
        .utmi_rxactive_i (utmi_rxactive_i),
        .enable_i        (enable_i),
        .evt             (u_evt_if.rx_mp)
    );

    log_word_builder u_builder
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ev           (u_evt_if.build_mp),
        .ignore_sof_i (ignore_sof_i),
        .mem_stall_i  (mem_stall_i),
        .wr_o         (wr_w),
        .word_o       (word_w)
    );

    log_mem_writer u_writer
    (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .enable_i        (enable_i),
        .buffer_base_i   (buffer_base_i),
        .buffer_end_i    (buffer_end_i),
        .wr_i            (wr_w),
        .word_i          (word_w),
        .mem_stall_i     (mem_stall_i),
        .mem_addr_o      (mem_addr_o),
        .mem_data_o      (mem_data_o),
        .mem_sel_o       (mem_sel_o),
        .mem_stb_o       (mem_stb_o),
        .mem_we_o        (mem_we_o),
        .sts_wrapped_o   (sts_wrapped_o),
        .sts_triggered_o (sts_triggered_o)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source. 8 ns clock period,
 * active high reset held for the first 16 cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #4 clk_o = ~clk_o;
    end

    // Release away from the active edge
    initial
    begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- usb_sniffer_assertions.sv
/*
 * Concurrent checks on the Wishbone side of the capture engine.
 * Bound into usb_sniffer_top by the bind statement below.
 */
`timescale 1ns/100ps
`default_nettype none

module usb_sniffer_assertions
(
    input logic                         clk_i,
    input logic                         rst_i,
    input logic                         stb_i,
    input logic                         stall_i,
    input logic                         we_i,
    input logic [3:0]                   sel_i,
    input usb_sniffer_pkg::log_word_t   data_i,
    input usb_sniffer_pkg::mem_addr_t   addr_i,
    input usb_sniffer_pkg::mem_addr_t   base_i,
    input usb_sniffer_pkg::mem_addr_t   end_i
);

    // Failed assertions so far, read at the end of the run
    int fail_count = 0;

    // Stalled write stays up with the same word
    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (stb_i && stall_i) |=> (stb_i && $stable(data_i)))
        else
        begin
            fail_count++;
            $error("Stalled write dropped or changed its word");
        end

    // Full-word writes only
    sel_we_ones: assert property (@(posedge clk_i) disable iff (rst_i)
        (sel_i == 4'hF) && we_i)
        else
        begin
            fail_count++;
            $error("Byte selects or write enable not all ones");
        end

    // Every write lands inside the buffer
    addr_in_buffer: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i |-> (addr_i >= base_i && addr_i <= end_i))
        else
        begin
            fail_count++;
            $error("Write address outside the log buffer");
        end

endmodule

bind usb_sniffer_top usb_sniffer_assertions u_assertions
(
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stb_i   (mem_stb_o),
    .stall_i (mem_stall_i),
    .we_i    (mem_we_o),
    .sel_i   (mem_sel_o),
    .data_i  (mem_data_o),
    .addr_i  (mem_addr_o),
    .base_i  (buffer_base_i),
    .end_i   (buffer_end_i)
);

`default_nettype wire

//--- tb_usb_sniffer.sv
/*
 * Testbench for the USB capture engine. Random UTMI packets from a seeded
 * xorshift source, a log model for expected writes and a Wishbone memory monitor.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_usb_sniffer;
    import usb_sniffer_pkg::*;

    logic       clk;
    logic       rst;
    utmi_byte_t utmi_data;
    logic       utmi_rxvalid;
    logic       utmi_rxactive;
    logic       enable;
    logic       ignore_sof;
    logic       mem_stall;
    mem_addr_t  buffer_base;
    mem_addr_t  buffer_end;
    mem_addr_t  mem_addr;
    log_word_t  mem_data;
    logic [3:0] mem_sel;
    logic       mem_stb;
    logic       mem_we;
    logic       sts_wrapped;
    logic       sts_triggered;

    // Expected writes in order of arrival
    log_word_t  exp_word_q[$];
    log_word_t  exp_mask_q[$];
    mem_addr_t  exp_addr_q[$];
    string      exp_name_q[$];

    // Buffer model
    mem_addr_t  model_addr;
    logic       model_wrapped;
    int         model_writes;

    int          word_errors;
    int          addr_errors;
    int          flag_errors;
    int          other_errors;
    logic        timed_out;
    int unsigned rng;
    string       test_name;
    utmi_byte_t  pkt [0:15];
    int          pkt_len;
    logic        pkt_is_data;

    pid_t token_pids [0:3] = '{PID_OUT, PID_IN, PID_SETUP, PID_PING};
    pid_t hshake_pids [0:3] = '{PID_ACK, PID_NAK, PID_STALL, PID_NYET};
    pid_t data_pids [0:3] = '{PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA};

    tb_clock_gen u_clk
    (
        .clk_o (clk),
        .rst_o (rst)
    );

    usb_sniffer_top UUT
    (
        .clk_i           (clk),
        .rst_i           (rst),
        .utmi_data_i     (utmi_data),
        .utmi_rxvalid_i  (utmi_rxvalid),
        .utmi_rxactive_i (utmi_rxactive),
        .enable_i        (enable),
        .ignore_sof_i    (ignore_sof),
        .buffer_base_i   (buffer_base),
        .buffer_end_i    (buffer_end),
        .mem_addr_o      (mem_addr),
        .mem_data_o      (mem_data),
        .mem_sel_o       (mem_sel),
        .mem_stb_o       (mem_stb),
        .mem_we_o        (mem_we),
        .mem_stall_i     (mem_stall),
        .sts_wrapped_o   (sts_wrapped),
        .sts_triggered_o (sts_triggered)
    );

    //------------------------------------------------------------
    // Random source
    //------------------------------------------------------------
    function automatic int unsigned xorshift32(input int unsigned x);
        int unsigned y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    //------------------------------------------------------------
    // Run end and reporting
    //------------------------------------------------------------
    task finish_run;
        int total;
        int assert_errors;
        assert_errors = UUT.u_assertions.fail_count;
        total = word_errors + addr_errors + flag_errors + other_errors + assert_errors;
        $display("Errors: word %0d, address %0d, flag %0d, other %0d, assertion %0d",
                 word_errors, addr_errors, flag_errors, other_errors, assert_errors);
        if (total == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task abort_run(input string why);
        $display("Timeout: %s", why);
        other_errors++;
        timed_out = 1'b1;
        finish_run;
    endtask

    task wait_reset;
        int t;
        t = 0;
        while (rst && t < 100)
        begin
            @(negedge clk);
            t++;
        end
        if (rst)
            abort_run("reset was never released");
    endtask

    // All modelled writes must reach memory
    task wait_drain;
        int t;
        t = 0;
        while (exp_word_q.size() != 0 && t < 100)
        begin
            @(negedge clk);
            t++;
        end
        if (exp_word_q.size() != 0)
            abort_run("expected log writes never reached memory");
    endtask

    task check_flags(input string name);
        logic exp_trig;
        exp_trig = (model_writes > 0);
        if (sts_triggered !== exp_trig)
        begin
            flag_errors++;
            $display("Error %s triggered flag: expected %0b actual %0b",
                     name, exp_trig, sts_triggered);
        end
        if (sts_wrapped !== model_wrapped)
        begin
            flag_errors++;
            $display("Error %s wrapped flag: expected %0b actual %0b",
                     name, model_wrapped, sts_wrapped);
        end
    endtask

    //------------------------------------------------------------
    // Log model
    //------------------------------------------------------------
    task expect_write(input log_word_t word, input logic is_header, input string name);
        exp_word_q.push_back(word);
        // Cycle delta not modelled
        exp_mask_q.push_back(is_header ? 32'hF00F_FFFF : 32'hFFFF_FFFF);
        exp_addr_q.push_back(model_addr);
        exp_name_q.push_back(name);
        model_writes++;
        // End address is the last slot
        if (model_addr == buffer_end)
        begin
            model_addr    = buffer_base;
            model_wrapped = 1'b1;
        end
        else
            model_addr = model_addr + 32'd4;
    endtask

    // Picks a packet, fills pkt and queues its expected words
    task build_packet;
        int unsigned kind;
        int unsigned n;
        int          i;
        logic [3:0]  nib;
        log_word_t   acc;
        kind        = rand_below(8);
        acc         = '0;
        pkt_is_data = 1'b0;
        if (kind < 2)
        begin
            test_name = "token";
            pkt[0]    = token_pids[rand_below(4)];
            pkt[1]    = utmi_byte_t'(rand_below(256));
            pkt[2]    = utmi_byte_t'(rand_below(256));
            pkt_len   = 3;
            if (enable)
                expect_write({4'd3, 8'h00, pkt[2], pkt[1], pkt[0][3:0]}, 1'b1, test_name);
        end
        else if (kind == 2)
        begin
            test_name = "sof";
            pkt[0]    = PID_SOF;
            pkt[1]    = utmi_byte_t'(rand_below(256));
            pkt[2]    = utmi_byte_t'(rand_below(256));
            pkt_len   = 3;
            // 11-bit frame, CRC5 bits dropped
            if (enable && !ignore_sof)
                expect_write({4'd1, 8'h00, 9'h000, pkt[2][2:0], pkt[1]}, 1'b1, test_name);
        end
        else if (kind == 3)
        begin
            test_name = "handshake";
            pkt[0]    = hshake_pids[rand_below(4)];
            pkt_len   = 1;
            if (enable)
                expect_write({4'd4, 8'h00, 16'h0000, pkt[0][3:0]}, 1'b1, test_name);
        end
        else if (kind < 7)
        begin
            test_name   = "data";
            pkt_is_data = 1'b1;
            pkt[0]      = data_pids[rand_below(4)];
            n           = rand_below(10);
            pkt_len     = n + 1;
            // Little-endian, four bytes a word
            for (i = 0; i < n; i++)
            begin
                pkt[i + 1] = utmi_byte_t'(rand_below(256));
                acc[8 * (i % 4) +: 8] = pkt[i + 1];
                if (i % 4 == 3)
                begin
                    if (enable)
                        expect_write(acc, 1'b0, "data payload");
                    acc = '0;
                end
            end
            if (enable && n % 4 != 0)
                expect_write(acc, 1'b0, "data payload");
            if (enable)
                expect_write({4'd5, 8'h00, 16'(n), pkt[0][3:0]}, 1'b1, "data header");
        end
        else
        begin
            // PRE, SPLIT or a code with no valid check nibble
            test_name = "ignored";
            nib       = 4'(rand_below(16));
            case (rand_below(4))
            0:
                pkt[0] = PID_PRE;
            1:
                pkt[0] = PID_SPLIT;
            default:
                pkt[0] = {nib, nib};
            endcase
            pkt_len = 1 + rand_below(4);
            for (i = 1; i < pkt_len; i++)
                pkt[i] = utmi_byte_t'(rand_below(256));
        end
    endtask

    //------------------------------------------------------------
    // UTMI driver
    //------------------------------------------------------------
    task send_packet;
        int i;
        for (i = 0; i < pkt_len; i++)
        begin
            @(negedge clk);
            utmi_rxactive = 1'b1;
            utmi_rxvalid  = 1'b1;
            utmi_data     = pkt[i];
        end
        @(negedge clk);
        utmi_rxactive = 1'b0;
        utmi_rxvalid  = 1'b0;
        utmi_data     = 8'h00;
    endtask

    // Idle gap of 12 or more cycles with an optional stall burst
    task idle_gap;
        int unsigned gap;
        int unsigned lead;
        int unsigned hold;
        gap  = 12 + rand_below(8);
        // Data header leaves two cycles after rxactive falls
        lead = pkt_is_data ? 2 : 0;
        hold = 0;
        repeat (lead) @(negedge clk);
        if (rand_below(3) == 0)
        begin
            hold      = 1 + rand_below(6);
            mem_stall = 1'b1;
            repeat (hold) @(negedge clk);
            mem_stall = 1'b0;
        end
        repeat (gap - lead - hold) @(negedge clk);
    endtask

    task run_random(input int count);
        int k;
        for (k = 0; k < count; k++)
        begin
            if (rand_below(8) == 0)
                ignore_sof = ~ignore_sof;
            build_packet;
            send_packet;
            idle_gap;
            wait_drain;
            check_flags(test_name);
        end
    endtask

    // Enable low then high, new buffer window
    task restart_capture(input mem_addr_t base, input mem_addr_t last);
        @(negedge clk);
        enable = 1'b0;
        repeat (4) @(negedge clk);
        buffer_base   = base;
        buffer_end    = last;
        enable        = 1'b1;
        model_addr    = base;
        model_wrapped = 1'b0;
        model_writes  = 0;
        repeat (2) @(negedge clk);
        check_flags("enable restart");
    endtask

    //------------------------------------------------------------
    // Memory monitor
    //------------------------------------------------------------
    always @(posedge clk)
    begin : write_monitor
        log_word_t exp_w;
        log_word_t mask;
        mem_addr_t exp_a;
        string     name;
        if (!rst && mem_stb && !mem_stall)
        begin
            if (exp_word_q.size() == 0)
            begin
                other_errors++;
                $display("Unexpected write of %h at address %h", mem_data, mem_addr);
            end
            else
            begin
                exp_w = exp_word_q.pop_front();
                mask  = exp_mask_q.pop_front();
                exp_a = exp_addr_q.pop_front();
                name  = exp_name_q.pop_front();
                if ((mem_data & mask) !== (exp_w & mask))
                begin
                    word_errors++;
                    $display("Error %s word: expected %h actual %h",
                             name, exp_w & mask, mem_data & mask);
                end
                if (mem_addr !== exp_a)
                begin
                    addr_errors++;
                    $display("Error %s address: expected %h actual %h", name, exp_a, mem_addr);
                end
            end
        end
    end

    //------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------
    initial
    begin
        rng           = 71;
        utmi_data     = 8'h00;
        utmi_rxvalid  = 1'b0;
        utmi_rxactive = 1'b0;
        enable        = 1'b0;
        ignore_sof    = 1'b0;
        mem_stall     = 1'b0;
        buffer_base   = 32'h0000_1000;
        buffer_end    = 32'h0000_102C;
        model_addr    = 32'h0000_1000;
        model_wrapped = 1'b0;
        model_writes  = 0;
        word_errors   = 0;
        addr_errors   = 0;
        flag_errors   = 0;
        other_errors  = 0;
        timed_out     = 1'b0;
        pkt_len       = 0;
        pkt_is_data   = 1'b0;
        wait_reset;

        // Capture off, nothing may be written
        run_random(6);

        // Twelve-slot buffer, wraps several times
        restart_capture(32'h0000_1000, 32'h0000_102C);
        run_random(60);
        if (!model_wrapped)
        begin
            other_errors++;
            $display("Buffer never wrapped in the first capture run");
        end

        // Restart at a new base with eight slots
        restart_capture(32'h0000_2000, 32'h0000_201C);
        run_random(40);

        finish_run;
    end

endmodule

`default_nettype wire

//--- usb_sniffer_top.f
usb_sniffer_pkg.sv
usb_rx_event_if.sv
utmi_packet_rx.sv
log_word_builder.sv
log_mem_writer.sv
usb_sniffer_top.sv
tb_clock_gen.sv
usb_sniffer_assertions.sv
tb_usb_sniffer.sv

//--- Bender.yml
package:
  name: usb_sniffer

sources:
  - usb_sniffer_pkg.sv
  - usb_rx_event_if.sv
  - utmi_packet_rx.sv
  - log_word_builder.sv
  - log_mem_writer.sv
  - usb_sniffer_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - usb_sniffer_assertions.sv
      - tb_usb_sniffer.sv
